/* astral_pad_pkg.sv */
/*
  Shared constants and the register word for the muxed padframe.
  Imported by the register block, the pad cells, the input router and the top level.
*/

package astral_pad_pkg;

  ////////////////////
  // register bus
  ////////////////////

  // 4 address bits leave room for up to 15 pads after the status word
  localparam int unsigned RegAddrWidth = 4;
  localparam int unsigned RegDataWidth = 32;

  // read-only boot status
  localparam logic [RegAddrWidth-1:0] StatusAddr = '0;

  // spi and ethernet data lanes
  localparam int unsigned PeriphLanes = 4;

  ////////////////////
  // mux select
  ////////////////////

  localparam int unsigned MuxSelWidth = 2;

  localparam logic [MuxSelWidth-1:0] MuxGpio     = MuxSelWidth'(0);
  localparam logic [MuxSelWidth-1:0] MuxSpi      = MuxSelWidth'(1);
  localparam logic [MuxSelWidth-1:0] MuxEth      = MuxSelWidth'(2);
  localparam logic [MuxSelWidth-1:0] MuxOff      = MuxSelWidth'(3);
  localparam logic [MuxSelWidth-1:0] MuxSelReset = MuxOff;

  // register word, read as pad config or as boot status
  typedef union packed {
    struct packed {
      logic [RegDataWidth-MuxSelWidth-1:0] reserved;
      logic [MuxSelWidth-1:0]              mux_sel;
    } pad_cfg;
    struct packed {
      logic [RegDataWidth-4:0] reserved;
      logic                    secure_boot;
      logic [1:0]              boot_mode;
    } boot_status;
  } reg_word_u;

endpackage

/* astral_padring.sv */
/*
  Padframe top level for the muxed pads. A register bus sets each pad to
  gpio, spi, ethernet or off; boot pins are captured during reset.
*/

`timescale 1ns/1ns

module astral_padring
  import astral_pad_pkg::*;
#(
  parameter int unsigned NumMuxPads = 8
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // pads
  input  logic [NumMuxPads-1:0]   pad_i,
  output logic [NumMuxPads-1:0]   pad_o,
  output logic [NumMuxPads-1:0]   pad_oe_o,
  // boot pins
  input  logic [1:0]              boot_mode_i,
  input  logic                    secure_boot_i,
  output logic [1:0]              boot_mode_o,
  output logic                    secure_boot_o,
  // soc side
  input  logic [NumMuxPads-1:0]   gpio_o_i,
  input  logic [NumMuxPads-1:0]   gpio_en_i,
  output logic [NumMuxPads-1:0]   gpio_i_o,
  input  logic [PeriphLanes-1:0]  spi_sd_o_i,
  input  logic [PeriphLanes-1:0]  spi_sd_en_i,
  output logic [PeriphLanes-1:0]  spi_sd_i_o,
  input  logic [PeriphLanes-1:0]  eth_txd_i,
  output logic [PeriphLanes-1:0]  eth_rxd_o,
  // register bus
  input  logic                    reg_valid_i,
  input  logic                    reg_write_i,
  input  logic [RegAddrWidth-1:0] reg_addr_i,
  input  reg_word_u               reg_wdata_i,
  output logic                    reg_rvalid_o,
  output reg_word_u               reg_rdata_o,
  output logic                    reg_error_o
);

  logic [NumMuxPads-1:0]                  pad_we;
  logic [MuxSelWidth-1:0]                 pad_sel_wdata;
  logic [NumMuxPads-1:0][MuxSelWidth-1:0] pad_sel;
  logic [NumMuxPads-1:0]                  gpio_in;
  logic [NumMuxPads-1:0]                  spi_in;
  logic [NumMuxPads-1:0]                  eth_in;

  pad_cfg_regs #(
    .NumMuxPads (NumMuxPads)
  ) i_pad_cfg_regs (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .reg_valid_i     (reg_valid_i),
    .reg_write_i     (reg_write_i),
    .reg_addr_i      (reg_addr_i),
    .reg_wdata_i     (reg_wdata_i),
    .boot_mode_i     (boot_mode_i),
    .secure_boot_i   (secure_boot_i),
    .pad_sel_i       (pad_sel),
    .pad_we_o        (pad_we),
    .pad_sel_wdata_o (pad_sel_wdata),
    .reg_rvalid_o    (reg_rvalid_o),
    .reg_rdata_o     (reg_rdata_o),
    .reg_error_o     (reg_error_o),
    .boot_mode_o     (boot_mode_o),
    .secure_boot_o   (secure_boot_o)
  );

  ////////////////////
  // pad row
  ////////////////////

  // pad k shares its spi and eth lane with every PeriphLanes-th pad
  for (genvar k = 0; k < NumMuxPads; k++) begin : gen_pads
    muxed_pad_cell i_muxed_pad_cell (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .we_i        (pad_we[k]),
      .sel_wdata_i (pad_sel_wdata),
      .pad_i       (pad_i[k]),
      .gpio_o_i    (gpio_o_i[k]),
      .gpio_en_i   (gpio_en_i[k]),
      .spi_sd_i    (spi_sd_o_i[k % PeriphLanes]),
      .spi_sd_en_i (spi_sd_en_i[k % PeriphLanes]),
      .eth_txd_i   (eth_txd_i[k % PeriphLanes]),
      .sel_o       (pad_sel[k]),
      .pad_o       (pad_o[k]),
      .pad_oe_o    (pad_oe_o[k]),
      .gpio_in_o   (gpio_in[k]),
      .spi_in_o    (spi_in[k]),
      .eth_in_o    (eth_in[k])
    );
  end

  pad_in_router #(
    .NumMuxPads (NumMuxPads)
  ) i_pad_in_router (
    .gpio_in_i  (gpio_in),
    .spi_in_i   (spi_in),
    .eth_in_i   (eth_in),
    .gpio_i_o   (gpio_i_o),
    .spi_sd_i_o (spi_sd_i_o),
    .eth_rxd_o  (eth_rxd_o)
  );

endmodule

/* astral_padring_chk.sv */
/*
  Register bus and reset checks for the padframe.
  Bound into every astral_padring instance by the bind at the bottom.
*/

`timescale 1ns/1ns

module astral_padring_chk #(
  parameter int unsigned NumMuxPads = 8
) (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  reg_valid_i,
  input logic                  reg_write_i,
  input logic                  reg_rvalid_o,
  input logic                  reg_error_o,
  input logic [NumMuxPads-1:0] pad_oe_o
);

  logic written_q;

  // set by the first write request after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      written_q <= 1'b0;
    end else if (reg_valid_i && reg_write_i) begin
      written_q <= 1'b1;
    end
  end

  rvalid_after_request: assert property (@(posedge clk_i) disable iff (reset_i)
    reg_valid_i |=> reg_rvalid_o)
    else $error("reg_rvalid_o missing one cycle after a request");

  no_rvalid_without_request: assert property (@(posedge clk_i) disable iff (reset_i)
    !reg_valid_i |=> !reg_rvalid_o)
    else $error("reg_rvalid_o without a request");

  error_with_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
    reg_error_o |-> reg_rvalid_o)
    else $error("reg_error_o outside a response");

  no_drive_before_write: assert property (@(posedge clk_i) disable iff (reset_i)
    !written_q |-> (pad_oe_o == '0))
    else $error("pad driver enabled before any write");

endmodule

bind astral_padring astral_padring_chk #(
  .NumMuxPads (NumMuxPads)
) i_astral_padring_chk (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .reg_valid_i  (reg_valid_i),
  .reg_write_i  (reg_write_i),
  .reg_rvalid_o (reg_rvalid_o),
  .reg_error_o  (reg_error_o),
  .pad_oe_o     (pad_oe_o)
);

/* files.f */
astral_pad_pkg.sv
pad_cfg_regs.sv
muxed_pad_cell.sv
pad_in_router.sv
astral_padring.sv
astral_padring_chk.sv
tb_astral_padring.sv

/* muxed_pad_cell.sv */
/*
  One muxed pad. Holds its own select and routes either a gpio bit, an spi
  lane or an ethernet lane to the pad, or parks the pad with the driver off.
*/

`timescale 1ns/1ns

module muxed_pad_cell
  import astral_pad_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   we_i,
  input  logic [MuxSelWidth-1:0] sel_wdata_i,
  input  logic                   pad_i,
  input  logic                   gpio_o_i,
  input  logic                   gpio_en_i,
  input  logic                   spi_sd_i,
  input  logic                   spi_sd_en_i,
  input  logic                   eth_txd_i,
  output logic [MuxSelWidth-1:0] sel_o,
  output logic                   pad_o,
  output logic                   pad_oe_o,
  output logic                   gpio_in_o,
  output logic                   spi_in_o,
  output logic                   eth_in_o
);

  logic [MuxSelWidth-1:0] sel_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q <= MuxSelReset;
    end else if (we_i) begin
      sel_q <= sel_wdata_i;
    end
  end

  assign sel_o = sel_q;

  // only the selected function sees the pad input
  always_comb begin
    pad_o     = 1'b0;
    pad_oe_o  = 1'b0;
    gpio_in_o = 1'b0;
    spi_in_o  = 1'b0;
    eth_in_o  = 1'b0;
    case (sel_q)
      MuxGpio: begin
        pad_o     = gpio_o_i;
        pad_oe_o  = gpio_en_i;
        gpio_in_o = pad_i;
      end
      MuxSpi: begin
        pad_o    = spi_sd_i;
        pad_oe_o = spi_sd_en_i;
        spi_in_o = pad_i;
      end
      // eth lanes have no enable of their own
      MuxEth: begin
        pad_o    = eth_txd_i;
        pad_oe_o = 1'b1;
        eth_in_o = pad_i;
      end
      default: begin
        pad_oe_o = 1'b0;
      end
    endcase
  end

endmodule

/* pad_cfg_regs.sv */
/*
  Register block of the padframe. Turns single-cycle requests into pad write
  strobes, answers every request one cycle later and keeps the boot pins
  as they were during reset.
*/

`timescale 1ns/1ns

module pad_cfg_regs
  import astral_pad_pkg::*;
#(
  parameter int unsigned NumMuxPads = 8
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   reg_valid_i,
  input  logic                                   reg_write_i,
  input  logic [RegAddrWidth-1:0]                reg_addr_i,
  input  reg_word_u                              reg_wdata_i,
  input  logic [1:0]                             boot_mode_i,
  input  logic                                   secure_boot_i,
  input  logic [NumMuxPads-1:0][MuxSelWidth-1:0] pad_sel_i,
  output logic [NumMuxPads-1:0]                  pad_we_o,
  output logic [MuxSelWidth-1:0]                 pad_sel_wdata_o,
  output logic                                   reg_rvalid_o,
  output reg_word_u                              reg_rdata_o,
  output logic                                   reg_error_o,
  output logic [1:0]                             boot_mode_o,
  output logic                                   secure_boot_o
);

  logic       addr_is_status;
  logic       addr_out_of_range;
  logic       req_error;
  reg_word_u  rdata_d;
  logic [1:0] boot_mode_q;
  logic       secure_boot_q;

  ////////////////////
  // request decode
  ////////////////////

  assign addr_is_status    = (reg_addr_i == StatusAddr);
  assign addr_out_of_range = (reg_addr_i > RegAddrWidth'(NumMuxPads));
  // status word is read-only
  assign req_error         = addr_out_of_range | (reg_write_i & addr_is_status);

  // address k+1 selects pad k
  always_comb begin
    for (int unsigned k = 0; k < NumMuxPads; k++) begin
      pad_we_o[k] = reg_valid_i & reg_write_i & (reg_addr_i == RegAddrWidth'(k + 1));
    end
  end

  assign pad_sel_wdata_o = reg_wdata_i.pad_cfg.mux_sel;

  // writes and bad addresses read back zero
  always_comb begin
    rdata_d = '0;
    if (!reg_write_i) begin
      if (addr_is_status) begin
        rdata_d.boot_status.boot_mode   = boot_mode_q;
        rdata_d.boot_status.secure_boot = secure_boot_q;
      end else begin
        for (int unsigned k = 0; k < NumMuxPads; k++) begin
          if (reg_addr_i == RegAddrWidth'(k + 1)) begin
            rdata_d.pad_cfg.mux_sel = pad_sel_i[k];
          end
        end
      end
    end
  end

  ////////////////////
  // response
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_rvalid_o <= 1'b0;
      reg_error_o  <= 1'b0;
    end else begin
      reg_rvalid_o <= reg_valid_i;
      reg_error_o  <= reg_valid_i & req_error;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_valid_i) begin
      reg_rdata_o <= rdata_d;
    end
  end

  // tracks the pins while reset is held, frozen afterwards
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      boot_mode_q   <= boot_mode_i;
      secure_boot_q <= secure_boot_i;
    end
  end

  assign boot_mode_o   = boot_mode_q;
  assign secure_boot_o = secure_boot_q;

endmodule

/* pad_in_router.sv */
/*
  Collects the gated pad inputs into the peripheral input buses.
  Pad k feeds spi and ethernet lane k modulo the lane count.
*/

`timescale 1ns/1ns

module pad_in_router
  import astral_pad_pkg::*;
#(
  parameter int unsigned NumMuxPads = 8
) (
  input  logic [NumMuxPads-1:0]  gpio_in_i,
  input  logic [NumMuxPads-1:0]  spi_in_i,
  input  logic [NumMuxPads-1:0]  eth_in_i,
  output logic [NumMuxPads-1:0]  gpio_i_o,
  output logic [PeriphLanes-1:0] spi_sd_i_o,
  output logic [PeriphLanes-1:0] eth_rxd_o
);

  // one gpio bit per pad
  assign gpio_i_o = gpio_in_i;

  // cells gate unselected inputs to zero, so a plain or merges them
  always_comb begin
    spi_sd_i_o = '0;
    eth_rxd_o  = '0;
    for (int unsigned k = 0; k < NumMuxPads; k++) begin
      spi_sd_i_o[k % PeriphLanes] = spi_sd_i_o[k % PeriphLanes] | spi_in_i[k];
      eth_rxd_o[k % PeriphLanes]  = eth_rxd_o[k % PeriphLanes] | eth_in_i[k];
    end
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the padring testbench with verilator and runs it
# exits 0 only when the testbench prints its pass line

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! verilator --binary --timing --assert --top-module tb_astral_padring -f files.f; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_astral_padring)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "sim passed" <<< "$sim_out"; then
  exit 0
fi

echo "pass line not found in simulation output"
exit 1

/* tb_astral_padring.sv */
/*
  Directed testbench for the muxed padframe with eight pads.
  Runs reset, readback, gpio, lane and error tests, then prints a summary.
*/

`timescale 1ns/1ns

module tb_astral_padring
  import astral_pad_pkg::*;
();

  localparam int unsigned NumMuxPads     = 8;
  localparam int unsigned ClkPeriod      = 4;
  localparam int unsigned ResetCycles    = 4;
  localparam int unsigned AccessCycles   = 2;
  localparam int unsigned ReadbackRounds = 2;
  localparam int unsigned LaneRounds     = 4;
  localparam int unsigned Vectors        = 8;
  // reset, readback, gpio, lanes and error tests, plus slack
  localparam int unsigned WatchdogCycles =
      ResetCycles + (NumMuxPads + 1) * AccessCycles
    + ReadbackRounds * 2 * NumMuxPads * AccessCycles
    + NumMuxPads * AccessCycles + Vectors
    + LaneRounds * (NumMuxPads * AccessCycles + Vectors)
    + (NumMuxPads + 4) * AccessCycles
    + 100;

  logic                    clk_i = 1'b0;
  logic                    reset_i;
  logic [NumMuxPads-1:0]   pad_i;
  logic [NumMuxPads-1:0]   pad_o;
  logic [NumMuxPads-1:0]   pad_oe_o;
  logic [1:0]              boot_mode_i;
  logic                    secure_boot_i;
  logic [1:0]              boot_mode_o;
  logic                    secure_boot_o;
  logic [NumMuxPads-1:0]   gpio_o_i;
  logic [NumMuxPads-1:0]   gpio_en_i;
  logic [NumMuxPads-1:0]   gpio_i_o;
  logic [PeriphLanes-1:0]  spi_sd_o_i;
  logic [PeriphLanes-1:0]  spi_sd_en_i;
  logic [PeriphLanes-1:0]  spi_sd_i_o;
  logic [PeriphLanes-1:0]  eth_txd_i;
  logic [PeriphLanes-1:0]  eth_rxd_o;
  logic                    reg_valid_i;
  logic                    reg_write_i;
  logic [RegAddrWidth-1:0] reg_addr_i;
  reg_word_u               reg_wdata_i;
  logic                    reg_rvalid_o;
  reg_word_u               reg_rdata_o;
  logic                    reg_error_o;

  logic [31:0]             rand_state = 32'd59;
  int unsigned             checks;
  int unsigned             errors;
  int unsigned             tests;
  logic [MuxSelWidth-1:0]  sel_exp [NumMuxPads];
  logic [1:0]              boot_mode_exp;
  logic                    secure_boot_exp;

  astral_padring #(
    .NumMuxPads (NumMuxPads)
  ) i_astral_padring (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_word(input string name, input reg_word_u got, input reg_word_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_pads(input string name, input logic [NumMuxPads-1:0] got,
                            input logic [NumMuxPads-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_lanes(input string name, input logic [PeriphLanes-1:0] got,
                             input logic [PeriphLanes-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: got %h, expected %h", name, got, exp);
    end
  endtask

  ////////////////////
  // register bus
  ////////////////////

  // one request, response expected exactly one cycle later
  task automatic reg_access(input logic wr, input int unsigned addr, input reg_word_u wdata,
                            output reg_word_u rdata, output logic err);
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= wr;
    reg_addr_i  <= RegAddrWidth'(addr);
    reg_wdata_i <= wdata;
    @(negedge clk_i);
    checks++;
    if (reg_rvalid_o) begin
      errors++;
      $display("response came in the request cycle, address %0d", addr);
    end
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    reg_write_i <= 1'b0;
    @(negedge clk_i);
    checks++;
    if (!reg_rvalid_o) begin
      errors++;
      $display("no response one cycle after the request, address %0d", addr);
    end
    rdata = reg_rdata_o;
    err   = reg_error_o;
  endtask

  task automatic configure_pad(input int unsigned k, input logic [MuxSelWidth-1:0] sel);
    reg_word_u wdata;
    reg_word_u rdata;
    logic      err;
    // reserved bits get noise, only mux_sel may land
    wdata = reg_word_u'(next_rand());
    wdata.pad_cfg.mux_sel = sel;
    reg_access(1'b1, k + 1, wdata, rdata, err);
    check_word("reg_rdata_o", rdata, '0);
    check_flag("reg_error_o", err, 1'b0);
    sel_exp[k] = sel;
  endtask

  task automatic check_pad_sel(input int unsigned k);
    reg_word_u exp;
    reg_word_u rdata;
    logic      err;
    exp = '0;
    exp.pad_cfg.mux_sel = sel_exp[k];
    reg_access(1'b0, k + 1, '0, rdata, err);
    check_word("reg_rdata_o", rdata, exp);
    check_flag("reg_error_o", err, 1'b0);
  endtask

  task automatic check_status();
    reg_word_u exp;
    reg_word_u got;
    reg_word_u rdata;
    logic      err;
    exp = '0;
    exp.boot_status.boot_mode   = boot_mode_exp;
    exp.boot_status.secure_boot = secure_boot_exp;
    reg_access(1'b0, int'(StatusAddr), '0, rdata, err);
    check_word("reg_rdata_o", rdata, exp);
    check_flag("reg_error_o", err, 1'b0);
    got = '0;
    got.boot_status.boot_mode   = boot_mode_o;
    got.boot_status.secure_boot = secure_boot_o;
    check_word("boot_mode_o/secure_boot_o", got, exp);
  endtask

  ////////////////////
  // pad row
  ////////////////////

  // expected pad and input-bus values from the selects and current inputs
  task automatic check_row();
    logic [NumMuxPads-1:0]  exp_o;
    logic [NumMuxPads-1:0]  exp_oe;
    logic [NumMuxPads-1:0]  exp_gpio;
    logic [PeriphLanes-1:0] exp_spi;
    logic [PeriphLanes-1:0] exp_eth;
    int unsigned            lane;
    exp_o    = '0;
    exp_oe   = '0;
    exp_gpio = '0;
    exp_spi  = '0;
    exp_eth  = '0;
    for (int unsigned k = 0; k < NumMuxPads; k++) begin
      lane = k % PeriphLanes;
      if (sel_exp[k] == MuxGpio) begin
        exp_o[k]    = gpio_o_i[k];
        exp_oe[k]   = gpio_en_i[k];
        exp_gpio[k] = pad_i[k];
      end else if (sel_exp[k] == MuxSpi) begin
        exp_o[k]      = spi_sd_o_i[lane];
        exp_oe[k]     = spi_sd_en_i[lane];
        exp_spi[lane] = exp_spi[lane] | pad_i[k];
      end else if (sel_exp[k] == MuxEth) begin
        exp_o[k]      = eth_txd_i[lane];
        exp_oe[k]     = 1'b1;
        exp_eth[lane] = exp_eth[lane] | pad_i[k];
      end
    end
    check_pads("pad_o", pad_o, exp_o);
    check_pads("pad_oe_o", pad_oe_o, exp_oe);
    check_pads("gpio_i_o", gpio_i_o, exp_gpio);
    check_lanes("spi_sd_i_o", spi_sd_i_o, exp_spi);
    check_lanes("eth_rxd_o", eth_rxd_o, exp_eth);
  endtask

  task automatic drive_random_vector();
    @(posedge clk_i);
    pad_i       <= NumMuxPads'(next_rand());
    gpio_o_i    <= NumMuxPads'(next_rand());
    gpio_en_i   <= NumMuxPads'(next_rand());
    spi_sd_o_i  <= PeriphLanes'(next_rand());
    spi_sd_en_i <= PeriphLanes'(next_rand());
    eth_txd_i   <= PeriphLanes'(next_rand());
    @(negedge clk_i);
    check_row();
  endtask

  task automatic report_test(input string name, input int unsigned errors_before);
    tests++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errors_before);
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_reset_state();
    int unsigned errors_before;
    errors_before = errors;
    // random soc side drive, off pads must ignore it
    drive_random_vector();
    for (int unsigned k = 0; k < NumMuxPads; k++) begin
      check_pad_sel(k);
    end
    check_status();
    report_test("reset state", errors_before);
  endtask

  task automatic test_readback();
    int unsigned errors_before;
    errors_before = errors;
    repeat (ReadbackRounds) begin
      for (int unsigned k = 0; k < NumMuxPads; k++) begin
        configure_pad(k, MuxSelWidth'(next_rand()));
      end
      for (int unsigned k = 0; k < NumMuxPads; k++) begin
        check_pad_sel(k);
      end
    end
    report_test("register readback", errors_before);
  endtask

  task automatic test_gpio_mode();
    int unsigned errors_before;
    errors_before = errors;
    for (int unsigned k = 0; k < NumMuxPads; k++) begin
      configure_pad(k, MuxGpio);
    end
    repeat (Vectors) drive_random_vector();
    report_test("gpio mode", errors_before);
  endtask

  task automatic test_lanes();
    int unsigned errors_before;
    errors_before = errors;
    repeat (LaneRounds) begin
      for (int unsigned k = 0; k < NumMuxPads; k++) begin
        configure_pad(k, MuxSelWidth'(next_rand()));
      end
      repeat (Vectors) drive_random_vector();
    end
    report_test("spi and eth lanes", errors_before);
  endtask

  task automatic test_errors();
    int unsigned errors_before;
    reg_word_u   wdata;
    reg_word_u   rdata;
    logic        err;
    errors_before = errors;
    wdata = reg_word_u'(next_rand());
    // status bits opposite to the held status so a landed write shows
    wdata.boot_status.boot_mode   = ~boot_mode_exp;
    wdata.boot_status.secure_boot = ~secure_boot_exp;
    reg_access(1'b0, NumMuxPads + 1, '0, rdata, err);
    check_flag("reg_error_o", err, 1'b1);
    check_word("reg_rdata_o", rdata, '0);
    reg_access(1'b1, 15, wdata, rdata, err);
    check_flag("reg_error_o", err, 1'b1);
    check_word("reg_rdata_o", rdata, '0);
    reg_access(1'b1, int'(StatusAddr), wdata, rdata, err);
    check_flag("reg_error_o", err, 1'b1);
    check_word("reg_rdata_o", rdata, '0);
    // status and pad selects untouched by the rejected writes
    check_status();
    for (int unsigned k = 0; k < NumMuxPads; k++) begin
      check_pad_sel(k);
    end
    report_test("error responses", errors_before);
  endtask

  initial begin
    reset_i         = 1'b1;
    pad_i           = NumMuxPads'(next_rand());
    gpio_o_i        = '0;
    gpio_en_i       = '0;
    spi_sd_o_i      = '0;
    spi_sd_en_i     = '0;
    eth_txd_i       = '0;
    reg_valid_i     = 1'b0;
    reg_write_i     = 1'b0;
    reg_addr_i      = '0;
    reg_wdata_i     = '0;
    boot_mode_exp   = 2'(next_rand());
    secure_boot_exp = 1'(next_rand());
    boot_mode_i     = boot_mode_exp;
    secure_boot_i   = secure_boot_exp;
    for (int unsigned k = 0; k < NumMuxPads; k++) begin
      sel_exp[k] = MuxOff;
    end
    repeat (ResetCycles) @(posedge clk_i);
    reset_i       <= 1'b0;
    // pins move once reset is gone, status must hold
    boot_mode_i   <= ~boot_mode_exp;
    secure_boot_i <= ~secure_boot_exp;
    test_reset_state();
    test_readback();
    test_gpio_mode();
    test_lanes();
    test_errors();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("watchdog expired, tests did not finish in %0d cycles", WatchdogCycles);
    $display("sim failed");
    $finish;
  end

endmodule
